// File: eth_tx_pkg.sv
`default_nettype none

`include "ethpipe_tx_defines.svh"

package eth_tx_pkg;

  import host_bus_pkg::*;

  // ------------------------------
  // slot memory
  // ------------------------------

  typedef logic [`ETH_PTR_W-1:0] slot_ptr_t;

  // host side port of the slot memory
  typedef struct packed {
    logic      en;
    logic      we;
    slot_ptr_t addr;
    bus_word_t data;
    byte_sel_t sel;
  } slot_wr_t;

  // length word at the head of each frame, in bytes
  typedef logic [15:0] frame_len_t;

  // ------------------------------
  // GMII side
  // ------------------------------

  typedef logic [7:0] gmii_byte_t;

  typedef struct packed {
    logic       en;
    gmii_byte_t data;
  } gmii_tx_t;

  typedef enum logic [2:0] {IDLE, LEN, PREAMBLE, DATA, GAP} sender_state_e;

endpackage

`default_nettype wire

// File: ethpipe_tx.f
+incdir+.
host_bus_pkg.sv
eth_tx_pkg.sv
tx_slot_ram.sv
host_regs.sv
gmii_sender.sv
ethpipe_tx_top.sv
tx_monitor.sv
tb_ethpipe_tx.sv

// File: ethpipe_tx_defines.svh
`ifndef ETHPIPE_TX_DEFINES_SVH
`define ETHPIPE_TX_DEFINES_SVH

// ------------------------------
// widths
// ------------------------------

// slot memory word address
`define ETH_PTR_W 14
`define ETH_CNT_W 64
`define ETH_BAR_W 7
// slave bus word address
`define ETH_ADR_W 19

// ------------------------------
// ethernet framing
// ------------------------------

// idle cycles between frames
`define ETH_IFG          12
`define ETH_PREAMBLE_LEN 7
`define ETH_PREAMBLE     8'h55
`define ETH_SFD          8'hD5

// ------------------------------
// BAR0 word addresses
// ------------------------------

`define REG_GCNT0     9'h002
`define REG_GCNT1     9'h003
`define REG_GCNT2     9'h004
`define REG_GCNT3     9'h005
`define REG_TX_WR_PTR 9'h018
`define REG_TX_RD_PTR 9'h01A

`endif

// File: ethpipe_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module ethpipe_tx_top
  import host_bus_pkg::*;
  import eth_tx_pkg::*;
(
  input  wire logic     clk_125,
  input  wire logic     sys_rst,
  // host slave bus
  input  wire slv_req_t host_req_i,
  output bus_word_t     host_rdata_o,
  // GMII transmit
  output gmii_tx_t      gmii_tx_o
);

  // host side of the slot memory
  slot_wr_t  slot_a;
  bus_word_t slot_a_q;

  // ring state between registers and sender
  slot_ptr_t tx_wr_ptr;
  slot_ptr_t tx_rd_ptr;

  // sender side of the slot memory
  slot_ptr_t mem_addr;
  bus_word_t mem_q;

  host_regs regs_i (
    .clk_125     (clk_125),
    .sys_rst     (sys_rst),
    .req_i       (host_req_i),
    .rdata_o     (host_rdata_o),
    .slot_o      (slot_a),
    .slot_q_i    (slot_a_q),
    .tx_wr_ptr_o (tx_wr_ptr),
    .tx_rd_ptr_i (tx_rd_ptr)
  );

  tx_slot_ram ram_i (
    .clk_125  (clk_125),
    .a_i      (slot_a),
    .a_q_o    (slot_a_q),
    .b_addr_i (mem_addr),
    .b_q_o    (mem_q)
  );

  gmii_sender sender_i (
    .clk_125    (clk_125),
    .sys_rst    (sys_rst),
    .wr_ptr_i   (tx_wr_ptr),
    .rd_ptr_o   (tx_rd_ptr),
    .mem_addr_o (mem_addr),
    .mem_q_i    (mem_q),
    .gmii_o     (gmii_tx_o)
  );

endmodule

`default_nettype wire

// File: gmii_sender.sv
`timescale 1ns/1ps
`default_nettype none

`include "ethpipe_tx_defines.svh"

module gmii_sender
  import host_bus_pkg::*;
  import eth_tx_pkg::*;
(
  input  wire logic      clk_125,
  input  wire logic      sys_rst,
  // ring pointers
  input  wire slot_ptr_t wr_ptr_i,
  output slot_ptr_t      rd_ptr_o,
  // slot memory port B
  output slot_ptr_t      mem_addr_o,
  input  wire bus_word_t mem_q_i,
  output gmii_tx_t       gmii_o
);

  // shared by the preamble and the gap count
  localparam int CNT_W = $clog2(`ETH_IFG + 1);

  sender_state_e    state;
  slot_ptr_t        rd_ptr;
  slot_ptr_t        addr;
  frame_len_t       remain;
  logic [CNT_W-1:0] cnt;
  logic             hi_byte;
  gmii_byte_t       data_byte;

  assign rd_ptr_o   = rd_ptr;
  assign mem_addr_o = addr;

  // upper byte of each word goes out first
  assign data_byte = hi_byte ? mem_q_i[15:8] : mem_q_i[7:0];

  // ------------------------------
  // frame FSM
  // ------------------------------

  // addr equals rd_ptr while idle, so the length word is already
  // on mem_q_i when LEN is entered
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      state   <= IDLE;
      rd_ptr  <= '0;
      addr    <= '0;
      remain  <= '0;
      cnt     <= '0;
      hi_byte <= 1'b1;
      gmii_o  <= '0;
    end else begin
      gmii_o.en <= 1'b0;
      case (state)
        IDLE: begin
          if (rd_ptr != wr_ptr_i)
            state <= LEN;
        end
        LEN: begin
          // point at the first data word, it arrives during the preamble
          remain <= mem_q_i;
          addr   <= addr + 1'b1;
          cnt    <= '0;
          state  <= PREAMBLE;
        end
        PREAMBLE: begin
          gmii_o.en <= 1'b1;
          if (cnt == CNT_W'(`ETH_PREAMBLE_LEN)) begin
            gmii_o.data <= `ETH_SFD;
            hi_byte     <= 1'b1;
            state       <= DATA;
          end else begin
            gmii_o.data <= `ETH_PREAMBLE;
            cnt         <= cnt + 1'b1;
          end
        end
        DATA: begin
          gmii_o.en   <= 1'b1;
          gmii_o.data <= data_byte;
          hi_byte     <= ~hi_byte;
          remain      <= remain - 1'b1;
          // next word address goes out now, mem_q_i still holds this word
          // for the low byte
          if (hi_byte)
            addr <= addr + 1'b1;
          if (remain == frame_len_t'(1)) begin
            cnt   <= '0;
            state <= GAP;
          end
        end
        GAP: begin
          cnt <= cnt + 1'b1;
          // addr has reached the head of the next frame
          if (cnt == CNT_W'(`ETH_IFG - 1)) begin
            rd_ptr <= addr;
            state  <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  // tx_en only for a queued frame in preamble or data
  tx_en_in_frame: assert property (@(posedge clk_125) disable iff (sys_rst)
    gmii_o.en |-> ($past(state) inside {PREAMBLE, DATA}) && (rd_ptr != wr_ptr_i))
    else $error("tx_en high outside a queued frame in preamble or data");

  // zero length word in the ring would run the frame forever
  len_nonzero: assert property (@(posedge clk_125) disable iff (sys_rst)
    (state == DATA) |-> (remain != '0))
    else $error("frame length is zero in DATA");

endmodule

`default_nettype wire

// File: host_bus_pkg.sv
`default_nettype none

`include "ethpipe_tx_defines.svh"

package host_bus_pkg;

  // ------------------------------
  // slave bus fields
  // ------------------------------

  typedef logic [15:0] bus_word_t;

  // bit 1 covers bits 15:8
  typedef logic [1:0] byte_sel_t;

  typedef logic [`ETH_BAR_W-1:0] bar_hit_t;
  typedef logic [`ETH_ADR_W-1:0] bus_adr_t;

  // one request per cycle with ce high, no stall
  typedef struct packed {
    bar_hit_t  bar;
    logic      ce;
    logic      we;
    bus_adr_t  adr;
    bus_word_t dat;
    byte_sel_t sel;
  } slv_req_t;

  // ------------------------------
  // register contents
  // ------------------------------

  typedef logic [`ETH_CNT_W-1:0] gcnt_t;

endpackage

`default_nettype wire

// File: host_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "ethpipe_tx_defines.svh"

module host_regs
  import host_bus_pkg::*;
  import eth_tx_pkg::*;
(
  input  wire logic      clk_125,
  input  wire logic      sys_rst,
  input  wire slv_req_t  req_i,
  output bus_word_t      rdata_o,
  // slot memory port A
  output slot_wr_t       slot_o,
  input  wire bus_word_t slot_q_i,
  // ring pointers
  output slot_ptr_t      tx_wr_ptr_o,
  input  wire slot_ptr_t tx_rd_ptr_i
);

  gcnt_t     gcnt;
  slot_ptr_t wr_ptr;
  bus_word_t bar0_rdata;
  bus_word_t bar0_q;
  logic      rd_from_slot;
  logic      bar0_hit;
  logic      bar2_hit;
  logic      wr_ptr_hit;

  // the host sees the low byte of a register on bits 15:8
  function automatic bus_word_t swap_bytes(input bus_word_t w);
    return {w[7:0], w[15:8]};
  endfunction

  assign bar0_hit   = req_i.ce & req_i.bar[0];
  assign bar2_hit   = req_i.ce & req_i.bar[2];
  assign wr_ptr_hit = bar0_hit & req_i.we & (req_i.adr[11:9] == 3'b000) &
                      (req_i.adr[8:0] == `REG_TX_WR_PTR);

  // free running global counter
  always_ff @(posedge clk_125) begin
    if (sys_rst)
      gcnt <= '0;
    else
      gcnt <= gcnt + 1'b1;
  end

  // ------------------------------
  // BAR0 register file
  // ------------------------------

  // read value of the addressed word, zero when unmapped
  always_comb begin
    bar0_rdata = '0;
    if (req_i.adr[11:9] == 3'b000) begin
      case (req_i.adr[8:0])
        `REG_GCNT0:     bar0_rdata = swap_bytes(gcnt[15:0]);
        `REG_GCNT1:     bar0_rdata = swap_bytes(gcnt[31:16]);
        `REG_GCNT2:     bar0_rdata = swap_bytes(gcnt[47:32]);
        `REG_GCNT3:     bar0_rdata = swap_bytes(gcnt[63:48]);
        `REG_TX_WR_PTR: bar0_rdata = swap_bytes(bus_word_t'(wr_ptr));
        `REG_TX_RD_PTR: bar0_rdata = swap_bytes(bus_word_t'(tx_rd_ptr_i));
        default:        bar0_rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      wr_ptr       <= '0;
      bar0_q       <= '0;
      rd_from_slot <= 1'b0;
    end else begin
      // high data byte holds ptr[7:0], low data byte ptr[13:8]
      if (wr_ptr_hit) begin
        if (req_i.sel[1])
          wr_ptr[7:0] <= req_i.dat[15:8];
        if (req_i.sel[0])
          wr_ptr[13:8] <= req_i.dat[5:0];
      end
      // remember which side answers the last read
      if (bar0_hit && !req_i.we) begin
        bar0_q       <= bar0_rdata;
        rd_from_slot <= 1'b0;
      end else if (bar2_hit && !req_i.we) begin
        rd_from_slot <= 1'b1;
      end
    end
  end

  // ------------------------------
  // BAR2 slot access
  // ------------------------------

  always_comb begin
    slot_o.en   = bar2_hit;
    slot_o.we   = req_i.we;
    slot_o.addr = req_i.adr[`ETH_PTR_W-1:0];
    slot_o.data = req_i.dat;
    slot_o.sel  = req_i.sel;
  end

  assign rdata_o     = rd_from_slot ? slot_q_i : bar0_q;
  assign tx_wr_ptr_o = wr_ptr;

  // BAR0 and BAR2 decode would both fire
  bar_onehot: assert property (@(posedge clk_125) disable iff (sys_rst)
    req_i.ce |-> !(req_i.bar[0] && req_i.bar[2]))
    else $error("request hits BAR0 and BAR2 at once");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, pass only if the log holds the pass line
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ethpipe_tx \
  -f ethpipe_tx.f -o sim_tx > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tx > sim.log 2>&1 || true
cat sim.log
grep -q "^RESULT: PASS$" sim.log && exit 0 || exit 1

// File: tb_ethpipe_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "ethpipe_tx_defines.svh"

module tb_ethpipe_tx
  import host_bus_pkg::*;
  import eth_tx_pkg::*;
();

  localparam bar_hit_t BAR0 = 7'b0000001;
  localparam bar_hit_t BAR2 = 7'b0000100;

  logic       clk_125;
  logic       sys_rst;
  slv_req_t   host_req;
  bus_word_t  host_rdata;
  gmii_tx_t   gmii_tx;
  int         err_cnt;
  int         frames;
  int         reads;
  int         pending;
  gcnt_t      ref_cnt;
  slot_ptr_t  wr_model;
  slot_ptr_t  ptr;
  slot_ptr_t  p1;
  bus_word_t  w;
  gmii_byte_t payload_q[$];
  gmii_byte_t stream_q[$];
  int         lens[4];
  int         limit;
  int         cycles = 0;
  int         n;

  ethpipe_tx_top dut_i (
    .clk_125      (clk_125),
    .sys_rst      (sys_rst),
    .host_req_i   (host_req),
    .host_rdata_o (host_rdata),
    .gmii_tx_o    (gmii_tx)
  );

  tx_monitor mon_i (
    .clk_125      (clk_125),
    .sys_rst      (sys_rst),
    .host_req_i   (host_req),
    .host_rdata_i (host_rdata),
    .gmii_tx_i    (gmii_tx),
    .err_cnt_o    (err_cnt),
    .frames_o     (frames),
    .reads_o      (reads),
    .pending_o    (pending)
  );

  initial begin
    clk_125 = 1'b0;
    forever #5 clk_125 = ~clk_125;
  end

  // counter value seen by a request sampled at the next edge
  always @(posedge clk_125) begin
    if (sys_rst)
      ref_cnt <= '0;
    else
      ref_cnt <= ref_cnt + 1'b1;
  end

  always @(posedge clk_125) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout: run passed its limit of %0d cycles", limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------

  function automatic slot_ptr_t next_ptr(input slot_ptr_t p, input int len);
    return p + slot_ptr_t'(1 + (len + 1) / 2);
  endfunction

  // preamble, SFD, then payload as it must appear on GMII
  function void build_stream();
    stream_q.delete();
    repeat (`ETH_PREAMBLE_LEN) stream_q.push_back(`ETH_PREAMBLE);
    stream_q.push_back(`ETH_SFD);
    foreach (payload_q[i]) stream_q.push_back(payload_q[i]);
  endfunction

  // ------------------------------
  // host bus tasks
  // ------------------------------

  task set_req(input bar_hit_t bar, input logic we, input int adr,
               input bus_word_t dat, input byte_sel_t sel);
    host_req.bar = bar;
    host_req.ce  = 1'b1;
    host_req.we  = we;
    host_req.adr = bus_adr_t'(adr);
    host_req.dat = dat;
    host_req.sel = sel;
  endtask

  task bus_idle();
    @(negedge clk_125);
    host_req = '0;
  endtask

  task read_reg(input bar_hit_t bar, input int adr, input bus_word_t exp,
                input logic swap, input string name);
    @(negedge clk_125);
    mon_i.post_read(exp, swap, name);
    set_req(bar, 1'b0, adr, '0, 2'b11);
  endtask

  task read_gcnt(input int idx);
    gcnt_t v;
    @(negedge clk_125);
    v = ref_cnt;
    mon_i.post_read(v[16*idx +: 16], 1'b1, $sformatf("host_rdata_o (GCNT%0d)", idx));
    set_req(BAR0, 1'b0, `REG_GCNT0 + idx, '0, 2'b11);
  endtask

  task set_wr(input bus_word_t dat, input byte_sel_t sel);
    @(negedge clk_125);
    set_req(BAR0, 1'b1, `REG_TX_WR_PTR, dat, sel);
    if (sel[1])
      wr_model[7:0] = dat[15:8];
    if (sel[0])
      wr_model[13:8] = dat[5:0];
  endtask

  // length word, packed bytes, then the expected stream goes to the monitor
  task write_frame(inout slot_ptr_t p, input int len);
    bus_word_t wd;
    payload_q.delete();
    repeat (len) payload_q.push_back(gmii_byte_t'($urandom));
    @(negedge clk_125);
    set_req(BAR2, 1'b1, p, bus_word_t'(len), 2'b11);
    for (int i = 0; i < len; i += 2) begin
      wd = {payload_q[i], (i + 1 < len) ? payload_q[i+1] : gmii_byte_t'($urandom)};
      @(negedge clk_125);
      set_req(BAR2, 1'b1, p + slot_ptr_t'(1 + i / 2), wd, 2'b11);
    end
    build_stream();
    foreach (stream_q[i]) mon_i.post_byte(stream_q[i]);
    mon_i.post_len(stream_q.size());
    p = next_ptr(p, len);
  endtask

  task wait_frames(input int cnt);
    while (frames < cnt) @(posedge clk_125);
    // read pointer moves at the end of the gap
    repeat (`ETH_IFG + 2) @(posedge clk_125);
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    void'($urandom(6272));
    host_req = '0;
    sys_rst  = 1'b1;
    wr_model = '0;
    limit    = 2000 + 2 * 256 * (8 + 2 + `ETH_IFG + 4);
    foreach (lens[i]) begin
      lens[i] = 1 + $urandom % 64;
      limit += 2 * (8 + lens[i] + `ETH_IFG + 4);
    end
    repeat (4) @(posedge clk_125);
    @(negedge clk_125);
    sys_rst = 1'b0;

    // values after reset, unmapped words read zero
    read_reg(BAR0, `REG_TX_WR_PTR, '0, 1'b1, "host_rdata_o (TX_WR_PTR)");
    read_reg(BAR0, `REG_TX_RD_PTR, '0, 1'b1, "host_rdata_o (TX_RD_PTR)");
    read_reg(BAR0, 'h010, '0, 1'b1, "host_rdata_o (unmapped)");
    read_reg(BAR0, 'h202, '0, 1'b1, "host_rdata_o (high page)");
    bus_idle();

    // counter, spaced reads then one burst
    read_gcnt(0);
    n = 3 + $urandom % 20;
    repeat (n) bus_idle();
    read_gcnt(0);
    for (int i = 0; i < 4; i++) read_gcnt(i);
    bus_idle();

    // slot memory
    repeat (8) begin
      ptr = slot_ptr_t'($urandom);
      w   = bus_word_t'($urandom);
      @(negedge clk_125);
      set_req(BAR2, 1'b1, ptr, w, 2'b11);
      read_reg(BAR2, ptr, w, 1'b0, "host_rdata_o (slot)");
    end
    bus_idle();

    // single frame at ring address 0
    ptr = '0;
    write_frame(ptr, lens[0]);
    set_wr({ptr[7:0], 2'b00, ptr[13:8]}, 2'b11);
    bus_idle();
    wait_frames(1);
    read_reg(BAR0, `REG_TX_RD_PTR, bus_word_t'(ptr), 1'b1, "host_rdata_o (TX_RD_PTR)");
    bus_idle();

    // three frames back to back
    for (int k = 1; k < 4; k++) write_frame(ptr, lens[k]);
    set_wr({ptr[7:0], 2'b00, ptr[13:8]}, 2'b11);
    bus_idle();
    wait_frames(4);
    read_reg(BAR0, `REG_TX_RD_PTR, bus_word_t'(wr_model), 1'b1, "host_rdata_o (TX_RD_PTR)");
    bus_idle();

    // write pointer byte mapping, with short frames filling the ring
    repeat (256) write_frame(ptr, 2);
    p1 = wr_model + slot_ptr_t'('h100);
    set_wr({p1[7:0], 2'b00, p1[13:8]}, 2'b11);
    read_reg(BAR0, `REG_TX_WR_PTR, bus_word_t'(p1), 1'b1, "host_rdata_o (TX_WR_PTR)");
    set_wr({~p1[7:0], 2'b00, p1[13:8] + 6'd1}, 2'b01);
    read_reg(BAR0, `REG_TX_WR_PTR, bus_word_t'(wr_model), 1'b1, "host_rdata_o (TX_WR_PTR)");
    bus_idle();
    wait_frames(260);
    read_reg(BAR0, `REG_TX_RD_PTR, bus_word_t'(wr_model), 1'b1, "host_rdata_o (TX_RD_PTR)");
    repeat (4) bus_idle();

    if (pending != 0)
      $display("%0d expected bytes or reads never appeared", pending);
    $display("errors %0d, frames %0d, reads %0d, missing %0d", err_cnt, frames, reads, pending);
    if (err_cnt == 0 && pending == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: tx_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "ethpipe_tx_defines.svh"

module tx_monitor
  import host_bus_pkg::*;
  import eth_tx_pkg::*;
(
  input  wire logic      clk_125,
  input  wire logic      sys_rst,
  input  wire slv_req_t  host_req_i,
  input  wire bus_word_t host_rdata_i,
  input  wire gmii_tx_t  gmii_tx_i,
  output int             err_cnt_o,
  output int             frames_o,
  output int             reads_o,
  output int             pending_o
);

  gmii_byte_t exp_bytes[$];
  int         exp_lens[$];
  bus_word_t  exp_rd[$];
  logic       exp_swap[$];
  string      exp_name[$];
  int         rd_err = 0;
  int         tx_err = 0;
  logic       rd_pending;
  logic       in_frame;
  int         byte_cnt;
  int         gap_cnt;
  gmii_byte_t exp_b;
  bus_word_t  exp_w;
  bus_word_t  act_w;
  logic       sw;
  string      nm;

  assign err_cnt_o = rd_err + tx_err;
  assign pending_o = exp_bytes.size() + exp_rd.size();

  task post_read(input bus_word_t v, input logic swap, input string name);
    exp_rd.push_back(v);
    exp_swap.push_back(swap);
    exp_name.push_back(name);
  endtask

  task post_byte(input gmii_byte_t b);
    exp_bytes.push_back(b);
  endtask

  task post_len(input int n);
    exp_lens.push_back(n);
  endtask

  // ------------------------------
  // host reads
  // ------------------------------

  always @(posedge clk_125) begin
    rd_pending <= !sys_rst && host_req_i.ce && !host_req_i.we &&
                  (host_req_i.bar[0] || host_req_i.bar[2]);
  end

  // read word is valid from the edge after the request
  always @(negedge clk_125) begin
    if (rd_pending === 1'b1) begin
      if (exp_rd.size() == 0) begin
        $display("a read returned data but no expected value was posted, time %0t", $time);
        rd_err++;
      end else begin
        exp_w = exp_rd.pop_front();
        sw    = exp_swap.pop_front();
        nm    = exp_name.pop_front();
        act_w = sw ? {host_rdata_i[7:0], host_rdata_i[15:8]} : host_rdata_i;
        if (act_w !== exp_w) begin
          $display("[ERROR] time %0t %s expected 0x%04h actual 0x%04h",
                   $time, nm, exp_w, act_w);
          rd_err++;
        end
        reads_o++;
      end
    end
  end

  // ------------------------------
  // GMII bursts
  // ------------------------------

  always @(posedge clk_125) begin
    if (sys_rst) begin
      in_frame = 1'b0;
      byte_cnt = 0;
      gap_cnt  = `ETH_IFG;
      frames_o = 0;
    end else if (gmii_tx_i.en) begin
      if (!in_frame) begin
        if (frames_o > 0 && gap_cnt < `ETH_IFG) begin
          $display("gap before frame %0d only %0d idle cycles, time %0t",
                   frames_o, gap_cnt, $time);
          tx_err++;
        end
        in_frame = 1'b1;
        byte_cnt = 0;
      end
      if (exp_bytes.size() == 0) begin
        $display("tx_en high while no frame was expected, time %0t", $time);
        tx_err++;
      end else begin
        exp_b = exp_bytes.pop_front();
        if (gmii_tx_i.data !== exp_b) begin
          $display("[ERROR] time %0t gmii_tx_o.data expected 0x%02h actual 0x%02h",
                   $time, exp_b, gmii_tx_i.data);
          tx_err++;
        end
      end
      byte_cnt++;
      gap_cnt = 0;
    end else begin
      if (in_frame) begin
        in_frame = 1'b0;
        if (exp_lens.size() == 0 || exp_lens.pop_front() != byte_cnt) begin
          $display("frame %0d has an unexpected length of %0d bytes, time %0t",
                   frames_o, byte_cnt, $time);
          tx_err++;
        end
        frames_o++;
      end
      gap_cnt++;
    end
  end

endmodule

`default_nettype wire

// File: tx_slot_ram.sv
`timescale 1ns/1ps
`default_nettype none

module tx_slot_ram
  import host_bus_pkg::*;
  import eth_tx_pkg::*;
(
  input  wire logic      clk_125,
  // port A, host side
  input  wire slot_wr_t  a_i,
  output bus_word_t      a_q_o,
  // port B, sender side, read only
  input  wire slot_ptr_t b_addr_i,
  output bus_word_t      b_q_o
);

  localparam int DEPTH = 2 ** $bits(slot_ptr_t);

  bus_word_t mem [DEPTH];

  // port A writes the selected bytes, reads otherwise
  // read word holds while the port is idle
  always_ff @(posedge clk_125) begin
    if (a_i.en) begin
      if (a_i.we) begin
        if (a_i.sel[1])
          mem[a_i.addr][15:8] <= a_i.data[15:8];
        if (a_i.sel[0])
          mem[a_i.addr][7:0] <= a_i.data[7:0];
      end else begin
        a_q_o <= mem[a_i.addr];
      end
    end
  end

  // port B reads every cycle
  always_ff @(posedge clk_125) begin
    b_q_o <= mem[b_addr_i];
  end

  // ------------------------------
  // checks
  // ------------------------------

  // host must present a clean address whenever it touches the memory
  a_addr_known: assert property (@(posedge clk_125)
    a_i.en |-> !$isunknown(a_i.addr))
    else $error("slot memory port A enabled with unknown address");

endmodule

`default_nettype wire
